// File: sources.f
logic/memPkg.sv
logic/memRequestIf.sv
logic/dataMemoryBus.sv
logic/dataMemoryAdapter.sv
logic/bankRouter.sv
logic/dataRamBank.sv
logic/accessSequencer.sv
logic/memAccessUnit.sv
sim/memAccessUnitTb.sv

// File: sim/memAccessUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessUnitTb;
    import memPkg::*;

    localparam int FILL_WORDS     = 2 * BANK_WORDS;
    localparam int BANK_PAIRS     = 8;
    localparam int RANDOM_PAIRS   = 150;
    localparam int MISALIGN_PAIRS = 40;
    localparam int TX_COUNT       = FILL_WORDS + 2 * (BANK_PAIRS + RANDOM_PAIRS + MISALIGN_PAIRS);
    localparam int TIMEOUT_CYCLES = TX_COUNT * 12 + 100;   // Worst case handshake plus idle

    logic      clock = 1'b0;
    logic      i_rstN;
    logic      i_req;
    logic      o_ack;
    DataAddr   i_addr;
    DataAccess i_access;
    logic      i_unsigned;
    logic      i_write;
    Data       i_wrData;
    Data       o_rdData;
    logic      o_alignError;

    logic [7:0]  model [2048];   // Byte image of the decoded 2 KiB
    logic [31:0] lfsrState = 32'h4c11_853a;
    int          cycleCount = 0;
    DataAddr     addr;
    DataAddr     loadAddr;
    DataAccess   access;
    logic        isUns;
    logic        write;
    Data         wrData;
    Data         rdData;
    logic        alignError;

    memAccessUnit uut (
        .i_clock      (clock),
        .i_rstN       (i_rstN),
        .i_req        (i_req),
        .o_ack        (o_ack),
        .i_addr       (i_addr),
        .i_access     (i_access),
        .i_unsigned   (i_unsigned),
        .i_write      (i_write),
        .i_wrData     (i_wrData),
        .o_rdData     (o_rdData),
        .o_alignError (o_alignError)
    );

    always #4 clock = ~clock;

    always @(posedge clock)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic int accessBytes(input DataAccess size);
        return (size == DataAccess_Byte) ? 1 : (size == DataAccess_Half) ? 2 : 4;
    endfunction

    function automatic logic isAligned(input DataAddr a, input DataAccess size);
        return (a[1:0] % accessBytes(size)) == 0;
    endfunction

    function automatic Data fillWord(input DataAddr a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic void modelStore(input DataAddr a, input DataAccess size, input Data d);
        if (isAligned(a, size))
        begin
            for (int b = 0; b < accessBytes(size); b++)
                model[a[10:0] + b] = d[8*b +: 8];   // Little-endian
        end
    endfunction

    function automatic Data modelLoad(input DataAddr a, input DataAccess size, input logic uns);
        Data  value;
        logic topBit;
        value = '0;
        for (int b = 0; b < accessBytes(size); b++)
            value[8*b +: 8] = model[a[10:0] + b];
        topBit = value[8*accessBytes(size) - 1];
        for (int bit_ = 8 * accessBytes(size); bit_ < DATA_WIDTH; bit_++)
            value[bit_] = !uns && topBit;
        return value;
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected %h, actual %h", testName, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // One full four-phase handshake with a random hold and idle time
    task automatic runAccess(input DataAddr a, input DataAccess size, input logic uns,
                             input logic wr, input Data d, output Data rd, output logic err);
        int waitCycles;
        int holdCycles;
        int idleCycles;
        holdCycles = randBits(2);
        idleCycles = randBits(2) % 3;
        @(posedge clock);
        i_req      <= 1'b1;
        i_addr     <= a;
        i_access   <= size;
        i_unsigned <= uns;
        i_write    <= wr;
        i_wrData   <= d;
        @(posedge clock);                  // First edge that samples i_req high
        @(negedge clock);
        waitCycles = 1;
        while (!o_ack && waitCycles < 8)
        begin
            @(negedge clock);
            waitCycles++;
        end
        checkValue("ack latency", 3, waitCycles);
        rd  = o_rdData;
        err = o_alignError;
        repeat (holdCycles)
        begin
            @(posedge clock);
            @(negedge clock);
            checkValue("ack hold", 1, o_ack);
            checkValue("data hold", rd, o_rdData);
        end
        @(posedge clock);
        i_req <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        checkValue("ack release", 0, o_ack);
        repeat (idleCycles) @(posedge clock);
    endtask

    initial
    begin
        i_rstN     <= 1'b0;
        i_req      <= 1'b0;
        i_addr     <= '0;
        i_access   <= DataAccess_Word;
        i_unsigned <= 1'b0;
        i_write    <= 1'b0;
        i_wrData   <= '0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        checkValue("reset ack", 0, o_ack);
        checkValue("reset align", 0, o_alignError);
        checkValue("reset data", 0, o_rdData);
        @(posedge clock);
        i_rstN <= 1'b1;

        // Known contents everywhere, so later loads never see unwritten RAM
        for (int w = 0; w < FILL_WORDS; w++)
        begin
            addr = DataAddr'(4 * w);
            runAccess(addr, DataAccess_Word, 1'b0, 1'b1, fillWord(addr), rdData, alignError);
            checkValue("fill align", 0, alignError);
            modelStore(addr, DataAccess_Word, fillWord(addr));
        end

        for (int i = 0; i < BANK_PAIRS; i++)
        begin
            addr    = randBits(32);
            addr[2] = i[0];                // Alternate even and odd bank
            addr[1:0] = 2'b00;
            wrData  = randBits(32);
            runAccess(addr, DataAccess_Word, 1'b0, 1'b1, wrData, rdData, alignError);
            modelStore(addr, DataAccess_Word, wrData);
            runAccess(addr, DataAccess_Word, 1'b0, 1'b0, '0, rdData, alignError);
            checkValue("bank word", wrData, rdData);
        end

        for (int i = 0; i < RANDOM_PAIRS; i++)
        begin
            addr   = randBits(32);
            access = randBits(1) ? DataAccess_Half : DataAccess_Byte;
            if (access == DataAccess_Half)
                addr[0] = 1'b0;
            wrData = randBits(32);
            runAccess(addr, access, 1'b0, 1'b1, wrData, rdData, alignError);
            checkValue("store align", 0, alignError);
            modelStore(addr, access, wrData);
            loadAddr       = randBits(21) << 11;   // Other alias
            loadAddr[10:2] = addr[10:2];           // Same word
            loadAddr[1:0]  = 2'(randBits(2));
            access   = DataAccess'(randBits(2) % 3);
            isUns    = randBits(1);
            runAccess(loadAddr, access, isUns, 1'b0, '0, rdData, alignError);
            if (isAligned(loadAddr, access))
            begin
                checkValue("load align", 0, alignError);
                checkValue("load data", modelLoad(loadAddr, access, isUns), rdData);
            end
            else
                checkValue("load misalign", 1, alignError);
        end

        for (int i = 0; i < MISALIGN_PAIRS; i++)
        begin
            addr   = randBits(32);
            access = randBits(1) ? DataAccess_Half : DataAccess_Word;
            if (access == DataAccess_Half)
                addr[0] = 1'b1;
            else if (addr[1:0] == 2'b00)
                addr[1:0] = 2'b10;
            write = randBits(1);
            runAccess(addr, access, 1'b0, write, randBits(32), rdData, alignError);
            checkValue("misalign flag", 1, alignError);
            loadAddr = {addr[31:2], 2'b00};
            runAccess(loadAddr, DataAccess_Word, 1'b0, 1'b0, '0, rdData, alignError);
            checkValue("misalign unchanged", modelLoad(loadAddr, DataAccess_Word, 1'b0), rdData);
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/memAccessUnit.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessUnit (
    input  logic              i_clock,
    input  logic              i_rstN,
    input  logic              i_req,
    output logic              o_ack,
    input  memPkg::DataAddr   i_addr,
    input  memPkg::DataAccess i_access,
    input  logic              i_unsigned,
    input  logic              i_write,
    input  memPkg::Data       i_wrData,
    output memPkg::Data       o_rdData,
    output logic              o_alignError
);

    memRequestIf  req ();
    dataMemoryBus cpuBus ();    // Adapter to router
    dataMemoryBus evenBus ();
    dataMemoryBus oddBus ();

    accessSequencer sequencer (
        .i_clock      (i_clock),
        .i_rstN       (i_rstN),
        .i_req        (i_req),
        .o_ack        (o_ack),
        .i_addr       (i_addr),
        .i_access     (i_access),
        .i_unsigned   (i_unsigned),
        .i_write      (i_write),
        .i_wrData     (i_wrData),
        .o_rdData     (o_rdData),
        .o_alignError (o_alignError),
        .req          (req.requester)
    );

    dataMemoryAdapter adapter (
        .i_clock (i_clock),
        .i_rstN  (i_rstN),
        .req     (req.formatter),
        .bus     (cpuBus.master)
    );

    bankRouter router (
        .i_clock (i_clock),
        .i_rstN  (i_rstN),
        .cpu     (cpuBus.slave),
        .even    (evenBus.master),
        .odd     (oddBus.master)
    );

    dataRamBank evenBank (
        .i_clock (i_clock),
        .bus     (evenBus.slave)
    );

    dataRamBank oddBank (
        .i_clock (i_clock),
        .bus     (oddBus.slave)
    );

endmodule

`default_nettype wire

// File: logic/accessSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module accessSequencer (
    input  logic              i_clock,
    input  logic              i_rstN,
    input  logic              i_req,
    output logic              o_ack,
    input  memPkg::DataAddr   i_addr,
    input  memPkg::DataAccess i_access,
    input  logic              i_unsigned,
    input  logic              i_write,
    input  memPkg::Data       i_wrData,
    output memPkg::Data       o_rdData,
    output logic              o_alignError,
    memRequestIf.requester    req
);
    import memPkg::*;

    typedef enum logic [1:0] {IDLE, ISSUE, CAPTURE, HOLD} State;

    State      state;
    DataAddr   addrReg;
    DataAccess accessReg;
    logic      unsignedReg;
    logic      writeReg;
    Data       wrDataReg;

    // Request payload, latched when a new request is accepted
    always_ff @(posedge i_clock)
    begin
        if (state == IDLE && i_req)
        begin
            addrReg     <= i_addr;
            accessReg   <= i_access;
            unsignedReg <= i_unsigned;
            writeReg    <= i_write;
            wrDataReg   <= i_wrData;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (!i_rstN)
        begin
            state        <= IDLE;
            o_ack        <= 1'b0;
            o_alignError <= 1'b0;
            o_rdData     <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (i_req)
                        state <= ISSUE;
                end
                ISSUE:
                begin
                    o_alignError <= req.alignError;   // Valid while enable is high
                    state        <= CAPTURE;
                end
                CAPTURE:
                begin
                    o_rdData <= writeReg ? '0 : req.rdData;
                    o_ack    <= 1'b1;
                    state    <= HOLD;
                end
                default:
                begin
                    if (!i_req)
                    begin
                        o_ack <= 1'b0;                 // Four-phase release
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    assign req.addr       = addrReg;
    assign req.access     = accessReg;
    assign req.isUnsigned = unsignedReg;
    assign req.wrData     = wrDataReg;
    assign req.wrEnable   = (state == ISSUE) && writeReg;    // Single-cycle pulse
    assign req.rdEnable   = (state == ISSUE) && !writeReg;

endmodule

`default_nettype wire

// File: logic/dataRamBank.sv
`timescale 1ns/1ps
`default_nettype none

module dataRamBank #(
    parameter int p_words = memPkg::BANK_WORDS
) (
    input  logic        i_clock,
    dataMemoryBus.slave bus
);
    import memPkg::*;

    Data                        mem [p_words];
    logic [$clog2(p_words)-1:0] wordIndex;

    // Word index sits just above the bank select bit
    assign wordIndex = bus.addr[BANK_SELECT_BIT+1 +: $clog2(p_words)];

    always_ff @(posedge i_clock)
    begin
        if (bus.wrEnable)
        begin
            for (int lane = 0; lane < DATA_WIDTH/8; lane++)
            begin
                if (bus.wrMask[lane])
                    mem[wordIndex][8*lane +: 8] <= bus.wrData[8*lane +: 8];
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (bus.rdEnable)
            bus.rdData <= mem[wordIndex];   // One cycle latency
    end

endmodule

`default_nettype wire

// File: logic/bankRouter.sv
`timescale 1ns/1ps
`default_nettype none

module bankRouter (
    input  logic         i_clock,
    input  logic         i_rstN,
    dataMemoryBus.slave  cpu,
    dataMemoryBus.master even,
    dataMemoryBus.master odd
);
    import memPkg::*;

    DataAddr bankAddr;
    logic    pickOdd;
    logic    readOdd;     // Bank choice of the pending read

    // Upper address bits alias onto the decoded range
    assign bankAddr = DataAddr'(cpu.addr[BANK_SELECT_BIT+BANK_INDEX_WIDTH:0]);
    assign pickOdd  = cpu.addr[BANK_SELECT_BIT];

    assign even.addr     = bankAddr;
    assign even.wrMask   = cpu.wrMask;
    assign even.wrData   = cpu.wrData;
    assign even.wrEnable = cpu.wrEnable && !pickOdd;
    assign even.rdEnable = cpu.rdEnable && !pickOdd;

    assign odd.addr      = bankAddr;
    assign odd.wrMask    = cpu.wrMask;
    assign odd.wrData    = cpu.wrData;
    assign odd.wrEnable  = cpu.wrEnable && pickOdd;
    assign odd.rdEnable  = cpu.rdEnable && pickOdd;

    always_ff @(posedge i_clock)
    begin
        if (!i_rstN)
            readOdd <= 1'b0;
        else if (cpu.rdEnable)
            readOdd <= pickOdd;    // Matches bank read latency
    end

    assign cpu.rdData = readOdd ? odd.rdData : even.rdData;

endmodule

`default_nettype wire

// File: logic/dataMemoryAdapter.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemoryAdapter (
    input  logic           i_clock,      // Unused, purely combinational
    input  logic           i_rstN,       // Unused
    memRequestIf.formatter req,
    dataMemoryBus.master   bus
);
    import memPkg::*;

    logic [1:0] byteOffset;
    logic       aligned;
    DataMask    laneMask;
    Data        sizedWrData;
    Data        laneRdData;
    logic       signFill;

    assign byteOffset = req.addr[1:0];

    // Size and offset decode
    always_comb
    begin
        aligned     = 1'b0;
        laneMask    = '0;
        sizedWrData = '0;
        case (req.access)
            DataAccess_Byte:
            begin
                aligned     = 1'b1;
                laneMask    = DataMask'(1) << byteOffset;
                sizedWrData = {{(DATA_WIDTH-8){1'b0}}, req.wrData[7:0]};
            end
            DataAccess_Half:
            begin
                aligned     = !byteOffset[0];
                laneMask    = byteOffset[1] ? 4'b1100 : 4'b0011;
                sizedWrData = {{(DATA_WIDTH-16){1'b0}}, req.wrData[15:0]};
            end
            DataAccess_Word:
            begin
                aligned     = (byteOffset == 2'b00);
                laneMask    = 4'b1111;
                sizedWrData = req.wrData;
            end
            default:
            begin
                aligned = 1'b0;                // Unknown size never aligns
            end
        endcase
    end

    assign bus.addr     = req.addr;
    assign bus.wrEnable = req.wrEnable;
    assign bus.rdEnable = req.rdEnable;
    assign bus.wrMask   = aligned ? laneMask : '0;   // Misaligned writes touch nothing
    assign bus.wrData   = sizedWrData << {byteOffset, 3'b000};

    // Little-endian lanes, addressed byte moves down to lane 0
    assign laneRdData = bus.rdData >> {byteOffset, 3'b000};

    always_comb
    begin
        signFill   = 1'b0;
        req.rdData = laneRdData;
        case (req.access)
            DataAccess_Byte:
            begin
                signFill   = !req.isUnsigned && laneRdData[7];
                req.rdData = {{(DATA_WIDTH-8){signFill}}, laneRdData[7:0]};
            end
            DataAccess_Half:
            begin
                signFill   = !req.isUnsigned && laneRdData[15];
                req.rdData = {{(DATA_WIDTH-16){signFill}}, laneRdData[15:0]};
            end
            default:
            begin
                req.rdData = laneRdData;       // Full word
            end
        endcase
    end

    assign req.alignError = !aligned && (req.wrEnable || req.rdEnable);

endmodule

`default_nettype wire

// File: logic/dataMemoryBus.sv
`timescale 1ns/1ps
`default_nettype none

interface dataMemoryBus;
    import memPkg::*;

    DataAddr addr;
    logic    wrEnable;
    logic    rdEnable;
    DataMask wrMask;       // One bit per byte lane
    Data     wrData;       // Already shifted into its lanes
    Data     rdData;       // Valid one cycle after rdEnable

    modport master (
        output addr,
        output wrEnable,
        output rdEnable,
        output wrMask,
        output wrData,
        input  rdData
    );

    modport slave (
        input  addr,
        input  wrEnable,
        input  rdEnable,
        input  wrMask,
        input  wrData,
        output rdData
    );

endinterface

`default_nettype wire

// File: logic/memRequestIf.sv
`timescale 1ns/1ps
`default_nettype none

interface memRequestIf;
    import memPkg::*;

    DataAddr   addr;
    DataAccess access;
    logic      isUnsigned;
    logic      wrEnable;
    logic      rdEnable;
    Data       wrData;
    Data       rdData;       // Extended load result
    logic      alignError;

    modport requester (
        output addr, access, isUnsigned, wrEnable, rdEnable, wrData,
        input  rdData, alignError
    );

    modport formatter (
        input  addr, access, isUnsigned, wrEnable, rdEnable, wrData,
        output rdData, alignError
    );

endinterface

`default_nettype wire

// File: logic/memPkg.sv
`default_nettype none

package memPkg;

    localparam int DATA_WIDTH = 32;

    typedef logic [DATA_WIDTH-1:0]   Data;
    typedef logic [31:0]             DataAddr;
    typedef logic [DATA_WIDTH/8-1:0] DataMask;   // Bit k enables bits 8k+7:8k

    typedef enum logic [1:0] {
        DataAccess_Byte,
        DataAccess_Half,
        DataAccess_Word
    } DataAccess;

    // Two banks side by side, 2 KiB decoded in total
    localparam int BANK_WORDS       = 256;
    localparam int BANK_INDEX_WIDTH = $clog2(BANK_WORDS);
    localparam int BANK_SELECT_BIT  = 2;        // Even/odd word select

endpackage

`default_nettype wire
